// File: common/procbus_params.svh
/*
 * Address map, keeper timeout and memory depth of the processor bus.
 * Included by every block that decodes addresses or sizes its storage.
 */
`ifndef PROCBUS_PARAMS_SVH
`define PROCBUS_PARAMS_SVH

// cycles the keeper waits for any slave response, at least 2
`define PROCBUS_TIMEOUT 16

// ----------------------------------------
// address map
// ----------------------------------------
`define PROCBUS_DMEM_BASE   32'h0000_0000
`define PROCBUS_DMEM_WORDS  64
`define PROCBUS_DMEM_BYTES  (`PROCBUS_DMEM_WORDS * 4)

`define PROCBUS_PERIPH_BASE  32'h0000_1000
`define PROCBUS_PERIPH_BYTES 16

`define PROCBUS_KEEPER_BASE  32'h0000_2000 // single status word
`define PROCBUS_KEEPER_BYTES 4

// value returned by the read-only peripheral id register
`define PROCBUS_PERIPH_ID 32'h5042_0001

`endif

// File: common/procbus_pkg.sv
/*
 * Shared types of the processor bus, referenced by scoped name.
 * Host side carries held levels, bus side carries one-cycle strobes.
 */
`default_nettype none

package procbus_pkg;

    typedef logic [31:0] addr_t; // byte address
    typedef logic [31:0] data_t; // data word

    // host request, held until ack or err comes back
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  rden;
        logic  wren;
    } host_req_t;

    // response pulse to one host
    typedef struct packed {
        data_t rdata;
        logic  ack;
        logic  err;
    } host_rsp_t;

    // shared bus request, rden/wren high for one cycle
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  rden;
        logic  wren;
    } bus_req_t;

    // slave response, all zeros when idle so responses can be ORed
    typedef struct packed {
        data_t rdata;
        logic  ack;
        logic  err;
    } slv_rsp_t;

    typedef enum logic [1:0] {
        IC_IDLE,   // waiting for a host request
        IC_STROBE, // bus strobe cycle
        IC_WAIT    // waiting for ack or err
    } ic_state_e;

endpackage

`default_nettype wire

// File: verilog/bus_interconnect.sv
/*
 * Two-host round-robin interconnect. Registers the granted request,
 * strobes it onto the shared bus, decodes the slave select and routes the
 * merged response back to the owning host only.
 */
`timescale 1ns/1ps
`default_nettype none
`include "procbus_params.svh"

module bus_interconnect (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    input  procbus_pkg::host_req_t host_req_i [2], // 0 fetch, 1 data
    output procbus_pkg::host_rsp_t host_rsp_o [2],
    output procbus_pkg::bus_req_t  bus_req_o,
    output logic                   sel_mem_o,
    output logic                   sel_periph_o,
    output logic                   sel_keeper_o,
    input  procbus_pkg::slv_rsp_t  slv_rsp_i [3],  // mem, periph, keeper
    input  wire                    keeper_err_i    // monitor error
);

    procbus_pkg::ic_state_e state_q;
    procbus_pkg::host_req_t req_q;    // latched request of the owner
    procbus_pkg::slv_rsp_t  merged;
    logic                   grant_q;  // owner, doubles as last grant
    logic                   grant;
    logic [1:0]             want;
    logic                   busy;
    logic                   done;

    // aligned power-of-two window match
    function automatic logic in_window(procbus_pkg::addr_t a, procbus_pkg::addr_t base,
                                       procbus_pkg::addr_t size);
        return (a & ~(size - 32'd1)) == base;
    endfunction

    // ----------------------------------------
    // arbitration
    // ----------------------------------------
    assign want[0] = host_req_i[0].rden | host_req_i[0].wren;
    assign want[1] = host_req_i[1].rden | host_req_i[1].wren;

    always_comb begin
        if (&want) grant = ~grant_q; // tie goes to the other host
        else       grant = want[1];
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= procbus_pkg::IC_IDLE;
            grant_q <= 1'b1; // host 0 wins the first tie
        end else begin
            case (state_q)
                procbus_pkg::IC_IDLE: if (|want) begin
                    state_q <= procbus_pkg::IC_STROBE;
                    grant_q <= grant;
                end
                procbus_pkg::IC_STROBE: state_q <= procbus_pkg::IC_WAIT;
                procbus_pkg::IC_WAIT:   if (done) state_q <= procbus_pkg::IC_IDLE;
                default:                state_q <= procbus_pkg::IC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == procbus_pkg::IC_IDLE) && |want) req_q <= host_req_i[grant];
    end

    // ----------------------------------------
    // bus side
    // ----------------------------------------
    assign busy = state_q != procbus_pkg::IC_IDLE;

    always_comb begin
        bus_req_o.addr  = req_q.addr;
        bus_req_o.wdata = req_q.wdata;
        bus_req_o.rden  = (state_q == procbus_pkg::IC_STROBE) & req_q.rden; // one cycle
        bus_req_o.wren  = (state_q == procbus_pkg::IC_STROBE) & req_q.wren;
    end

    assign sel_mem_o    = busy & in_window(req_q.addr, `PROCBUS_DMEM_BASE, `PROCBUS_DMEM_BYTES);
    assign sel_periph_o = busy & in_window(req_q.addr, `PROCBUS_PERIPH_BASE,
                                           `PROCBUS_PERIPH_BYTES);
    assign sel_keeper_o = busy & in_window(req_q.addr, `PROCBUS_KEEPER_BASE,
                                           `PROCBUS_KEEPER_BYTES);

    // ----------------------------------------
    // response routing
    // ----------------------------------------
    always_comb begin
        merged = '0;
        for (int i = 0; i < 3; i++) begin
            merged.rdata = merged.rdata | slv_rsp_i[i].rdata;
            merged.ack   = merged.ack | slv_rsp_i[i].ack;
            merged.err   = merged.err | slv_rsp_i[i].err;
        end
        merged.err = merged.err | keeper_err_i; // stall or late device error
    end

    assign done = (state_q == procbus_pkg::IC_WAIT) & (merged.ack | merged.err);

    always_comb begin
        for (int h = 0; h < 2; h++) begin
            host_rsp_o[h] = '0;
            if ((state_q == procbus_pkg::IC_WAIT) && (int'(grant_q) == h)) begin
                host_rsp_o[h].rdata = merged.rdata;
                host_rsp_o[h].ack   = merged.ack;
                host_rsp_o[h].err   = merged.err;
            end
        end
    end

    // a transfer never addresses two slaves
    ap_sel_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0({sel_mem_o, sel_periph_o, sel_keeper_o}))
        else $error("interconnect selects more than one slave");

endmodule

`default_nettype wire

// File: bus_keeper/bus_keeper.sv
/*
 * Bus keeper. Watches every strobed transfer and ends it with an error
 * when the slave reports one or nothing answers in time, and keeps the
 * cause in a sticky status word that clears on any access.
 */
`timescale 1ns/1ps
`default_nettype none
`include "procbus_params.svh"

module bus_keeper (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  procbus_pkg::bus_req_t bus_req_i, // monitored bus
    input  wire                   bus_ack_i, // merged slave ack
    input  wire                   bus_err_i, // merged slave err
    input  wire                   sel_i,     // status register select
    output procbus_pkg::slv_rsp_t rsp_o,
    output logic                  err_o      // monitor error pulse
);

    localparam int   CNT_W       = $clog2(`PROCBUS_TIMEOUT);
    localparam logic ERR_DEVICE  = 1'b0;
    localparam logic ERR_TIMEOUT = 1'b1;

    // monitor state
    logic             pending_q;
    logic [CNT_W-1:0] timeout_q;
    logic             expired;
    logic             mon_err_q;  // registered error, drives err_o
    logic             mon_type_q;

    // status register
    logic                  err_flag_q; // sticky
    logic                  err_type_q;
    logic                  ack_q;
    procbus_pkg::data_t    rdata_q;

    logic strobe;
    logic acc;

    assign strobe  = bus_req_i.rden | bus_req_i.wren;
    assign acc     = sel_i & strobe;
    assign expired = (timeout_q == '0);

    // ----------------------------------------
    // transfer monitor
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q  <= 1'b0;
            timeout_q  <= '0;
            mon_err_q  <= 1'b0;
            mon_type_q <= ERR_DEVICE;
        end else begin
            mon_err_q <= 1'b0;
            if (!pending_q) begin
                timeout_q <= CNT_W'(`PROCBUS_TIMEOUT - 1); // reload while idle
                pending_q <= strobe;
            end else if (bus_err_i) begin // slave ended with error
                mon_err_q  <= 1'b1;
                mon_type_q <= ERR_DEVICE;
                pending_q  <= 1'b0;
            end else if (bus_ack_i) begin // normal end
                pending_q <= 1'b0;
            end else if (expired) begin
                mon_err_q  <= 1'b1;
                mon_type_q <= ERR_TIMEOUT;
                pending_q  <= 1'b0;
            end else begin
                timeout_q <= timeout_q - 1'b1;
            end
        end
    end

    assign err_o = mon_err_q;

    // ----------------------------------------
    // status register
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            err_flag_q <= 1'b0;
            err_type_q <= ERR_DEVICE;
            ack_q      <= 1'b0;
            rdata_q    <= '0;
        end else begin
            if (mon_err_q) begin // new error beats the clear
                err_flag_q <= 1'b1;
                err_type_q <= mon_type_q;
            end else if (acc) begin
                err_flag_q <= 1'b0;
            end
            ack_q   <= acc;
            rdata_q <= '0;
            if (acc && bus_req_i.rden) begin
                rdata_q <= {err_flag_q, 30'b0, err_type_q}; // flag bit 31, type bit 0
            end
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.ack   = ack_q;
    assign rsp_o.err   = 1'b0; // own register never fails

    // interconnect must wait for the end of a transfer
    ap_no_overlap: assert property (@(posedge clk_i) disable iff (!rstn_i)
        pending_q |-> !strobe)
        else $error("bus strobe while a transfer is pending");

    // a failed transfer is never also acknowledged
    ap_err_no_ack: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(err_o && bus_ack_i))
        else $error("keeper error together with bus ack");

endmodule

`default_nettype wire

// File: verilog/data_mem.sv
/*
 * Word data memory on the processor bus.
 * Writes land on the strobe, reads return with ack one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none
`include "procbus_params.svh"

module data_mem (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  procbus_pkg::bus_req_t bus_req_i,
    input  wire                   sel_i,
    output procbus_pkg::slv_rsp_t rsp_o
);

    localparam int IDX_W = $clog2(`PROCBUS_DMEM_WORDS);

    procbus_pkg::data_t mem [`PROCBUS_DMEM_WORDS];
    procbus_pkg::data_t rdata_q; // zero unless a read answers
    logic               ack_q;
    logic [IDX_W-1:0]   idx;
    logic               acc;

    assign idx = bus_req_i.addr[IDX_W+1:2]; // drop byte offset
    assign acc = sel_i & (bus_req_i.rden | bus_req_i.wren);

    always_ff @(posedge clk_i) begin
        if (sel_i && bus_req_i.wren) mem[idx] <= bus_req_i.wdata;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            ack_q   <= acc;
            rdata_q <= (sel_i && bus_req_i.rden) ? mem[idx] : '0;
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.ack   = ack_q;
    assign rsp_o.err   = 1'b0;

endmodule

`default_nettype wire

// File: verilog/slow_periph.sv
/*
 * Slow peripheral with delay, scratch and read-only id registers.
 * Each access is answered delay+1 cycles after its strobe; writes to the
 * id word or the unused last word answer with err.
 */
`timescale 1ns/1ps
`default_nettype none
`include "procbus_params.svh"

module slow_periph (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  procbus_pkg::bus_req_t bus_req_i,
    input  wire                   sel_i,
    output procbus_pkg::slv_rsp_t rsp_o
);

    logic [7:0]         delay_q;   // response delay, offset 0
    procbus_pkg::data_t scratch_q; // offset 4
    logic [7:0]         cnt_q;
    logic               busy_q;
    logic               bad_q;     // answer with err
    procbus_pkg::data_t rdata_q;
    logic [1:0]         off;
    logic               acc;
    logic               respond;

    assign off = bus_req_i.addr[3:2]; // word offset in the window
    assign acc = sel_i & (bus_req_i.rden | bus_req_i.wren);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            delay_q   <= '0;
            scratch_q <= '0;
            cnt_q     <= '0;
            busy_q    <= 1'b0;
            bad_q     <= 1'b0;
        end else begin
            if (acc) begin
                busy_q <= 1'b1;
                cnt_q  <= delay_q; // old delay applies to this access
                bad_q  <= bus_req_i.wren & off[1]; // id or offset 12
            end else if (busy_q) begin
                if (cnt_q == '0) busy_q <= 1'b0;
                else             cnt_q  <= cnt_q - 1'b1;
            end
            if (acc && bus_req_i.wren) begin
                case (off)
                    2'd0:    delay_q   <= bus_req_i.wdata[7:0];
                    2'd1:    scratch_q <= bus_req_i.wdata;
                    default: ; // read-only or unused
                endcase
            end
        end
    end

    // read data captured at the strobe
    always_ff @(posedge clk_i) begin
        if (acc) begin
            rdata_q <= '0;
            if (bus_req_i.rden) begin
                case (off)
                    2'd0:    rdata_q <= {24'b0, delay_q};
                    2'd1:    rdata_q <= scratch_q;
                    2'd2:    rdata_q <= `PROCBUS_PERIPH_ID;
                    default: rdata_q <= '0;
                endcase
            end
        end
    end

    assign respond     = busy_q & (cnt_q == '0);
    assign rsp_o.rdata = respond ? rdata_q : '0;
    assign rsp_o.ack   = respond & ~bad_q;
    assign rsp_o.err   = respond & bad_q;

endmodule

`default_nettype wire

// File: verilog/procbus_top.sv
/*
 * Processor bus subsystem with two host ports.
 * Joins the interconnect, the bus keeper, data memory and slow peripheral.
 */
`timescale 1ns/1ps
`default_nettype none

module procbus_top (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    input  procbus_pkg::host_req_t host_req_i [2], // 0 fetch, 1 data
    output procbus_pkg::host_rsp_t host_rsp_o [2]
);

    procbus_pkg::bus_req_t bus_req;
    procbus_pkg::slv_rsp_t slv_rsp [3]; // mem, periph, keeper
    logic                  sel_mem;
    logic                  sel_periph;
    logic                  sel_keeper;
    logic                  keeper_err;
    logic                  bus_ack;
    logic                  bus_err;

    // merged slave handshake seen by the keeper
    assign bus_ack = slv_rsp[0].ack | slv_rsp[1].ack | slv_rsp[2].ack;
    assign bus_err = slv_rsp[0].err | slv_rsp[1].err | slv_rsp[2].err;

    bus_interconnect u_ic (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .host_req_i   (host_req_i),
        .host_rsp_o   (host_rsp_o),
        .bus_req_o    (bus_req),
        .sel_mem_o    (sel_mem),
        .sel_periph_o (sel_periph),
        .sel_keeper_o (sel_keeper),
        .slv_rsp_i    (slv_rsp),
        .keeper_err_i (keeper_err)
    );

    bus_keeper u_keeper (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .bus_req_i (bus_req),
        .bus_ack_i (bus_ack),
        .bus_err_i (bus_err),
        .sel_i     (sel_keeper),
        .rsp_o     (slv_rsp[2]),
        .err_o     (keeper_err)
    );

    data_mem u_dmem (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .bus_req_i (bus_req),
        .sel_i     (sel_mem),
        .rsp_o     (slv_rsp[0])
    );

    slow_periph u_periph (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .bus_req_i (bus_req),
        .sel_i     (sel_periph),
        .rsp_o     (slv_rsp[1])
    );

endmodule

`default_nettype wire

// File: tests/tb_procbus.sv
/*
 * Random regression of the processor bus. The testbench acts as both hosts
 * and checks every response against a model of memory, peripheral and keeper.
 */
`timescale 1ns/1ps
`default_nettype none
`include "procbus_params.svh"

module tb_procbus;

    localparam int CYCLE_LIMIT = 20000; // wide margin over the length of all tests

    logic                   clk;
    logic                   rstn;
    procbus_pkg::host_req_t host_req [2]; // 0 fetch, 1 data
    procbus_pkg::host_rsp_t host_rsp [2];

    logic [31:0]        lfsr;
    procbus_pkg::data_t mem_model [`PROCBUS_DMEM_WORDS];
    logic [7:0]         delay_model;
    procbus_pkg::data_t scratch_model;
    logic               flag_model;  // sticky keeper flag
    logic               type_model;  // 1 timeout, 0 device
    int                 checks;
    int                 errors;
    int                 test_checks;
    int                 test_errors;
    int                 cycles;

    procbus_top dut (
        .clk_i      (clk),
        .rstn_i     (rstn),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
        $display("Regression failed");
        $finish;
    end

    // a response must only reach a host that is holding a request
    always @(negedge clk) begin
        for (int h = 0; h < 2; h++) begin
            if ((host_rsp[h].ack || host_rsp[h].err) &&
                !(host_req[h].rden || host_req[h].wren)) begin
                $display("host %0d got a response without a request at %0d ns", h, $time);
                errors++;
                test_errors++;
            end
        end
    end

    // ----------------------------------------
    // random numbers and checks
    // ----------------------------------------
    // feedback polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        test_checks++;
        if (actual !== expected) begin
            $display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // ----------------------------------------
    // model and host ports
    // ----------------------------------------
    // expected response and model update for one access
    task automatic model_access(input logic wr, input procbus_pkg::addr_t addr,
                                input procbus_pkg::data_t wdata,
                                output procbus_pkg::data_t exp_rd, output logic exp_err,
                                output int drain);
        exp_rd  = '0;
        exp_err = 1'b0;
        drain   = 0;
        if (addr < (`PROCBUS_DMEM_BASE + `PROCBUS_DMEM_BYTES)) begin
            if (wr) mem_model[int'((addr - `PROCBUS_DMEM_BASE) >> 2)] = wdata;
            else    exp_rd = mem_model[int'((addr - `PROCBUS_DMEM_BASE) >> 2)];
        end else if (addr >= `PROCBUS_PERIPH_BASE &&
                     addr < (`PROCBUS_PERIPH_BASE + `PROCBUS_PERIPH_BYTES)) begin
            if (delay_model >= 8'(`PROCBUS_TIMEOUT)) begin // keeper gives up first
                exp_err    = 1'b1;
                drain      = int'(delay_model); // late answer still on its way
                flag_model = 1'b1;
                type_model = 1'b1;
            end else if (wr && addr[3]) begin // id and last word refuse writes
                exp_err    = 1'b1;
                flag_model = 1'b1;
                type_model = 1'b0;
            end else if (!wr) begin
                case (addr[3:2])
                    2'd0:    exp_rd = {24'b0, delay_model};
                    2'd1:    exp_rd = scratch_model;
                    2'd2:    exp_rd = `PROCBUS_PERIPH_ID;
                    default: exp_rd = '0;
                endcase
            end
            if (wr && addr[3:2] == 2'd0) delay_model = wdata[7:0]; // lands even on timeout
            if (wr && addr[3:2] == 2'd1) scratch_model = wdata;
        end else if (addr >= `PROCBUS_KEEPER_BASE &&
                     addr < (`PROCBUS_KEEPER_BASE + `PROCBUS_KEEPER_BYTES)) begin
            if (!wr) exp_rd = {flag_model, 30'b0, type_model};
            flag_model = 1'b0; // any access clears
        end else begin
            exp_err    = 1'b1; // nobody answers an unmapped address
            flag_model = 1'b1;
            type_model = 1'b1;
        end
    endtask

    // request held until ack or err and dropped at the next edge
    task automatic host_access(input int h, input logic wr, input procbus_pkg::addr_t addr,
                               input procbus_pkg::data_t wdata,
                               output procbus_pkg::host_rsp_t rsp);
        @(posedge clk);
        #1;
        host_req[h].addr  = addr;
        host_req[h].wdata = wdata;
        host_req[h].rden  = ~wr;
        host_req[h].wren  = wr;
        do begin
            @(negedge clk);
        end while (!(host_rsp[h].ack || host_rsp[h].err));
        rsp = host_rsp[h];
        @(posedge clk);
        #1;
        host_req[h] = '0;
    endtask

    task automatic run_access(input int h, input logic wr, input procbus_pkg::addr_t addr,
                              input procbus_pkg::data_t wdata);
        procbus_pkg::data_t     exp_rd;
        logic                   exp_err;
        int                     drain;
        procbus_pkg::host_rsp_t rsp;
        model_access(wr, addr, wdata, exp_rd, exp_err, drain);
        host_access(h, wr, addr, wdata, rsp);
        check_value($sformatf("host_rsp[%0d].ack", h), 32'(!exp_err), 32'(rsp.ack));
        check_value($sformatf("host_rsp[%0d].err", h), 32'(exp_err), 32'(rsp.err));
        check_value($sformatf("host_rsp[%0d].rdata", h), exp_rd, rsp.rdata);
        repeat (drain) @(posedge clk);
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    initial begin
        procbus_pkg::addr_t a0;
        procbus_pkg::addr_t a1;
        procbus_pkg::data_t d0;
        procbus_pkg::data_t d1;
        logic [31:0]        idx0;
        logic [31:0]        idx1;
        logic               wr;
        int                 h;
        lfsr          = 32'h161cdf07;
        rstn          = 1'b0;
        host_req[0]   = '0;
        host_req[1]   = '0;
        delay_model   = '0;
        scratch_model = '0;
        flag_model    = 1'b0;
        type_model    = 1'b0;
        checks        = 0;
        errors        = 0;
        test_checks   = 0;
        test_errors   = 0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        // test 1 fills memory and then mixes random traffic of both hosts
        for (int i = 0; i < `PROCBUS_DMEM_WORDS; i++) begin
            a0 = `PROCBUS_DMEM_BASE + 32'(i * 4);
            run_access(i % 2, 1'b1, a0, ~a0 ^ {a0[15:0], a0[31:16]});
        end
        for (int i = 0; i < 200; i++) begin
            h    = int'(next_bit());
            wr   = next_bit();
            idx0 = rand_bits(6);
            d0   = rand_bits(32);
            run_access(h, wr, `PROCBUS_DMEM_BASE + (idx0 << 2), wr ? d0 : '0);
        end
        report_test("1 memory random");

        // test 2 lets both hosts request at once
        for (int i = 0; i < 50; i++) begin
            idx0 = rand_bits(6);
            idx1 = (idx0 + 32'd1 + rand_bits(6) % 32'd63) % 32'd64; // never idx0
            a0   = `PROCBUS_DMEM_BASE + (idx0 << 2);
            a1   = `PROCBUS_DMEM_BASE + (idx1 << 2);
            d0   = rand_bits(32);
            d1   = rand_bits(32);
            fork
                run_access(0, 1'b1, a0, d0);
                run_access(1, 1'b1, a1, d1);
            join
            // cross reads expose swapped responses
            fork
                run_access(0, 1'b0, a1, '0);
                run_access(1, 1'b0, a0, '0);
            join
        end
        report_test("2 contention");

        // test 3 sweeps delays from 0 to T-3
        for (int i = 0; i < 20; i++) begin
            h  = int'(next_bit());
            d0 = rand_bits(4) % (`PROCBUS_TIMEOUT - 2);
            d1 = rand_bits(32);
            run_access(h, 1'b1, `PROCBUS_PERIPH_BASE, d0);
            run_access(h, 1'b1, `PROCBUS_PERIPH_BASE + 4, d1);
            run_access(h, 1'b0, `PROCBUS_PERIPH_BASE + 4, '0);
            run_access(h, 1'b0, `PROCBUS_PERIPH_BASE + 8, '0);
            run_access(h, 1'b0, `PROCBUS_PERIPH_BASE, '0);
        end
        report_test("3 peripheral delay");

        // test 4 sets a delay beyond the keeper timeout
        run_access(0, 1'b1, `PROCBUS_PERIPH_BASE, 32'(`PROCBUS_TIMEOUT + 4));
        run_access(1, 1'b0, `PROCBUS_PERIPH_BASE + 4, '0);
        run_access(1, 1'b0, `PROCBUS_KEEPER_BASE, '0); // flag and timeout type
        run_access(0, 1'b0, `PROCBUS_KEEPER_BASE, '0); // flag gone
        run_access(0, 1'b1, `PROCBUS_PERIPH_BASE, '0); // restore runs with the old delay
        run_access(0, 1'b0, `PROCBUS_KEEPER_BASE, '0);
        report_test("4 peripheral timeout");

        // test 5 causes a device error and then hits an unmapped address
        run_access(1, 1'b1, `PROCBUS_PERIPH_BASE + 8, rand_bits(32));
        run_access(0, 1'b0, `PROCBUS_KEEPER_BASE, '0);
        run_access(0, 1'b0, `PROCBUS_KEEPER_BASE, '0);
        run_access(1, 1'b0, 32'h0000_3000, '0);
        run_access(1, 1'b1, `PROCBUS_KEEPER_BASE, rand_bits(32)); // write clears too
        run_access(0, 1'b0, `PROCBUS_KEEPER_BASE, '0);
        report_test("5 keeper errors");

        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: procbus.f
+incdir+common
common/procbus_pkg.sv
verilog/bus_interconnect.sv
bus_keeper/bus_keeper.sv
verilog/data_mem.sv
verilog/slow_periph.sv
verilog/procbus_top.sv
tests/tb_procbus.sv

// File: Makefile
# Verilator build and run of the processor bus regression

BIN  := obj_dir/Vtb_procbus
SRCS := procbus.f $(wildcard common/*.sv common/*.svh verilog/*.sv bus_keeper/*.sv tests/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_procbus -f procbus.f

# the status comes from grep, so a failing run fails the target
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
